/* verilog/badger_pkg.sv */
// Rx badger shared definitions
package badger_pkg;

	// Packet buffer address width that holds a maximum frame and its badge
	localparam int PAW = 11;

	// One byte of the incoming stream
	typedef logic [7:0] octet_t;

	// Packet buffer word with the start-of-frame flag in bit 8
	typedef logic [8:0] buf_word_t;

	// Address into the packet buffer RAM
	typedef logic [PAW-1:0] pbuf_addr_t;

	// Frame length in octets that saturates at all ones
	typedef logic [10:0] pack_len_t;

	// Badge status byte
	// Bit 0 is FCS good, bit 1 runt and bit 2 giant while the rest reads as zero
	typedef logic [7:0] status_t;

	// Rx MAC memory address with the bank select in the top bit
	typedef logic [11:0] mac_addr_t;

	// Running CRC-32 register
	typedef logic [31:0] crc_t;

	// Words in the badge that precedes each frame in the buffer
	localparam int BADGE_LEN = 5;

	// The MAC copy leaves out the dummy word and keeps four header words
	localparam int MAC_HDR_LEN = 4;

	// Ethernet size limits in octets with the FCS included
	localparam pack_len_t MIN_FRAME = 11'd64;
	localparam pack_len_t MAX_FRAME = 11'd1518;

	// Reflected form of the 802.3 polynomial 0x04C11DB7
	localparam crc_t CRC_POLY = 32'hEDB88320;

	// Register contents after running a correct FCS through the CRC
	localparam crc_t CRC_RESIDUE = 32'hDEBB20E3;

	// Writer phase whose values double as the word offset inside the badge
	typedef enum logic [2:0] {
		PH_DUMMY    = 3'd0,
		PH_LEN_LO   = 3'd1,
		PH_LEN_HI   = 3'd2,
		PH_STATUS   = 3'd3,
		PH_RESERVED = 3'd4,
		PH_PASS     = 3'd5
	} badge_phase_e;

endpackage

/* verilog/frame_scanner.sv */
// Frame length scanner
`timescale 1ns/1ps

module frame_scanner
	import badger_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      data_s,
	input  logic      data_f,
	output pack_len_t pack_len,
	output logic      runt,
	output logic      giant
);

	// Previous strobe, used to find the first octet of a frame
	logic      data_s_d;
	logic      trig;

	// Running count of octets in the current frame
	pack_len_t octet_cnt;

	assign trig = data_s & ~data_s_d;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_s_d <= 1'b0;
		end else begin
			data_s_d <= data_s;
		end
	end

	// The first octet loads a count of one, later octets add to it
	// Saturation keeps oversized frames flagged as giants
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			octet_cnt <= '0;
		end else if (trig) begin
			octet_cnt <= pack_len_t'(1);
		end else if (data_s && octet_cnt != '1) begin
			octet_cnt <= octet_cnt + pack_len_t'(1);
		end
	end

	// Results are taken at frame end and hold until the next frame is done
	// The counter already includes the last octet by the data_f cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pack_len <= '0;
			runt     <= 1'b0;
			giant    <= 1'b0;
		end else if (data_f) begin
			pack_len <= octet_cnt;
			// Runts are short of the minimum, FCS octets counted
			runt     <= octet_cnt < MIN_FRAME;
			// Giants exceed the maximum untagged frame size
			giant    <= octet_cnt > MAX_FRAME;
		end
	end

endmodule

/* verilog/fcs_checker.sv */
// Ethernet FCS checker
`timescale 1ns/1ps

module fcs_checker
	import badger_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  octet_t data_in,
	input  logic   data_s,
	input  logic   data_f,
	output logic   fcs_ok
);

	// Previous strobe, marks the first octet of each frame
	logic data_s_d;
	logic trig;

	// Running CRC over everything seen so far in the frame
	crc_t crc;

	// Seed used for the first octet of a frame
	crc_t crc_seed;

	assign trig = data_s & ~data_s_d;

	// On the first octet the old remainder is ignored and all ones used instead
	assign crc_seed = trig ? '1 : crc;

	// Bytewise update, bit 0 of the octet enters first as on the wire
	// Eight serial steps unroll into one layer of XOR logic per octet
	function automatic crc_t crc_byte(crc_t crc_in, octet_t octet);
		crc_t c;
		c = crc_in ^ crc_t'(octet);
		for (int b = 0; b < 8; b++) begin
			if (c[0]) begin
				c = (c >> 1) ^ CRC_POLY;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_s_d <= 1'b0;
		end else begin
			data_s_d <= data_s;
		end
	end

	// The FCS itself runs through the same update as the payload
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			crc <= '1;
		end else if (data_s) begin
			crc <= crc_byte(crc_seed, data_in);
		end
	end

	// A frame with a correct FCS leaves the fixed residue behind
	// No final inversion is needed when comparing against it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fcs_ok <= 1'b0;
		end else if (data_f) begin
			fcs_ok <= crc == CRC_RESIDUE;
		end
	end

endmodule

/* verilog/pbuf_writer.sv */
// Packet buffer and Rx MAC writer
`timescale 1ns/1ps

module pbuf_writer
	import badger_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  octet_t     data_in,
	input  logic       data_s,
	input  logic       data_f,
	input  pack_len_t  pack_len,
	input  logic       runt,
	input  logic       giant,
	input  logic       fcs_ok,
	input  logic       rx_mac_hbank,
	input  logic       rx_mac_accept,
	output buf_word_t  mem_d,
	output pbuf_addr_t mem_a,
	output octet_t     rx_mac_d,
	output mac_addr_t  rx_mac_a,
	output logic       rx_mac_wen,
	output logic [1:0] rx_mac_buf_status,
	output pbuf_addr_t gray_state,
	output logic       badge_stb
);

	// Free running frame pointer, the reference for all buffer addresses
	pbuf_addr_t   fp;
	// Registered write address and data that go straight to the RAM
	pbuf_addr_t   fpp;
	buf_word_t    pxd;
	// Where the badge of the current frame starts
	pbuf_addr_t   origin;
	badge_phase_e phase;
	status_t      status_r;
	logic         data_s_d;
	logic         trig;
	logic         badge_stb_r;

	// MAC side state
	logic [10:0]  mac_a0;
	logic         mac_bank;
	logic         rx_mac_hbank_r;
	logic         bank_ready;
	logic         mac_save;
	logic         mac_stopping;
	logic         mac_queue;

	pbuf_addr_t   fp_gray;
	pbuf_addr_t   gray_state_r;

	assign trig = data_s & ~data_s_d;

	// Results from the scanner and checker settle one cycle after data_f
	// They are latched while the dummy word goes out, well before use
	always_ff @(posedge clk) begin
		if (phase == PH_DUMMY) begin
			status_r <= {5'b0, giant, runt, fcs_ok};
		end
	end

	// Phase sequencing, data_f kicks off the five badge words
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= PH_PASS;
		end else if (data_f) begin
			phase <= PH_DUMMY;
		end else begin
			case (phase)
				PH_DUMMY:    phase <= PH_LEN_LO;
				PH_LEN_LO:   phase <= PH_LEN_HI;
				PH_LEN_HI:   phase <= PH_STATUS;
				PH_STATUS:   phase <= PH_RESERVED;
				default:     phase <= PH_PASS;
			endcase
		end
	end

	// Address generation for the buffer RAM
	// Outside the badge everything lands BADGE_LEN words ahead of fp
	// Idle cycles write junk there too, it is ahead of the next origin
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_s_d    <= 1'b0;
			fp          <= '0;
			fpp         <= '0;
			origin      <= '0;
			badge_stb_r <= 1'b0;
		end else begin
			data_s_d <= data_s;
			fp       <= fp + pbuf_addr_t'(1);
			if (trig) begin
				origin <= fp;
			end
			if (phase == PH_PASS) begin
				fpp <= fp + pbuf_addr_t'(BADGE_LEN);
			end else begin
				// Phase value is the word offset inside the badge
				fpp <= origin + pbuf_addr_t'(phase);
			end
			// The dummy word is not strobed, only the four real header words
			badge_stb_r <= phase != PH_DUMMY && phase != PH_PASS;
		end
	end

	// Word contents, start-of-frame marker in bit 8 of the first two words
	always_ff @(posedge clk) begin
		case (phase)
			PH_DUMMY:    pxd <= {1'b1, 8'h00};
			PH_LEN_LO:   pxd <= {1'b1, 1'b0, pack_len[6:0]};
			PH_LEN_HI:   pxd <= {1'b0, 4'h0, pack_len[10:7]};
			PH_STATUS:   pxd <= {1'b0, status_r};
			PH_RESERVED: pxd <= {1'b0, 8'h00};
			default:     pxd <= {1'b0, data_in};
		endcase
	end

	assign mem_a     = fpp;
	assign mem_d     = pxd;
	assign badge_stb = badge_stb_r;

	// Bank handshake with the host
	// Host bank bit likely comes from another clock domain, one capture stage
	assign bank_ready        = mac_bank != rx_mac_hbank_r;
	assign rx_mac_buf_status = {rx_mac_hbank_r, mac_bank};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_mac_hbank_r <= 1'b1;
			mac_bank       <= 1'b0;
			mac_save       <= 1'b0;
			mac_stopping   <= 1'b0;
			mac_queue      <= 1'b0;
			mac_a0         <= '0;
		end else begin
			rx_mac_hbank_r <= rx_mac_hbank;
			// Payload starts after the header slots, header rewinds to zero
			if (trig) begin
				mac_a0 <= 11'(MAC_HDR_LEN);
			end else if (phase == PH_LEN_LO) begin
				mac_a0 <= '0;
			end else begin
				mac_a0 <= mac_a0 + 11'd1;
			end
			// Saving only starts when the host has left a bank for us
			if (trig && bank_ready) begin
				mac_save <= 1'b1;
			end
			// Length low word is on the port while the phase is PH_LEN_HI
			if (phase == PH_LEN_HI && mac_save && rx_mac_accept) begin
				mac_queue <= 1'b1;
			end
			mac_stopping <= phase == PH_RESERVED;
			// Last header word goes out this cycle, then hand the bank over
			if (mac_stopping) begin
				mac_save <= 1'b0;
				if (mac_queue) begin
					mac_bank  <= ~mac_bank;
					mac_queue <= 1'b0;
				end
			end
		end
	end

	// Writes are limited to payload octets and the four header words
	assign rx_mac_d   = pxd[7:0];
	assign rx_mac_a   = {mac_bank, mac_a0};
	assign rx_mac_wen = mac_save & (data_s_d | badge_stb_r);

	// Gray coded pointer so a reader in another domain can sample it safely
	assign fp_gray = fp ^ (fp >> 1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gray_state_r <= '0;
		end else begin
			gray_state_r <= fp_gray;
		end
	end

	assign gray_state = gray_state_r;

endmodule

/* verilog/packet_dpram.sv */
// Packet buffer RAM
`timescale 1ns/1ps

module packet_dpram
	import badger_pkg::*;
(
	input  logic       clk,
	input  pbuf_addr_t wr_a,
	input  buf_word_t  wr_d,
	input  pbuf_addr_t host_a,
	output buf_word_t  host_q
);

	// Ring of packet words, sized by the package address width
	buf_word_t mem [2**PAW];

	// Write side has no enable, the writer owns every cycle
	always_ff @(posedge clk) begin
		mem[wr_a] <= wr_d;
	end

	// Host read data appears one cycle after the address
	// A read of the word being written returns the old contents
	always_ff @(posedge clk) begin
		host_q <= mem[host_a];
	end

endmodule

/* verilog/rx_badger.sv */
// Rx badger top level
`timescale 1ns/1ps

module rx_badger
	import badger_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  octet_t     data_in,
	input  logic       data_s,
	input  logic       data_f,
	input  logic       rx_mac_hbank,
	input  logic       rx_mac_accept,
	input  pbuf_addr_t host_a,
	output buf_word_t  host_q,
	output octet_t     rx_mac_d,
	output mac_addr_t  rx_mac_a,
	output logic       rx_mac_wen,
	output logic [1:0] rx_mac_buf_status,
	output pbuf_addr_t gray_state,
	output logic       badge_stb
);

	// Scanner and checker results
	pack_len_t  pack_len;
	logic       runt;
	logic       giant;
	logic       fcs_ok;

	// Writer to RAM
	buf_word_t  mem_d;
	pbuf_addr_t mem_a;

	// Length and size flags, in parallel with the CRC
	frame_scanner frame_scanner_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.data_s   (data_s),
		.data_f   (data_f),
		.pack_len (pack_len),
		.runt     (runt),
		.giant    (giant)
	);

	fcs_checker fcs_checker_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.data_in (data_in),
		.data_s  (data_s),
		.data_f  (data_f),
		.fcs_ok  (fcs_ok)
	);

	pbuf_writer pbuf_writer_inst (
		.clk               (clk),
		.arst_n            (arst_n),
		.data_in           (data_in),
		.data_s            (data_s),
		.data_f            (data_f),
		.pack_len          (pack_len),
		.runt              (runt),
		.giant             (giant),
		.fcs_ok            (fcs_ok),
		.rx_mac_hbank      (rx_mac_hbank),
		.rx_mac_accept     (rx_mac_accept),
		.mem_d             (mem_d),
		.mem_a             (mem_a),
		.rx_mac_d          (rx_mac_d),
		.rx_mac_a          (rx_mac_a),
		.rx_mac_wen        (rx_mac_wen),
		.rx_mac_buf_status (rx_mac_buf_status),
		.gray_state        (gray_state),
		.badge_stb         (badge_stb)
	);

	// Host reads frames back through the second port
	packet_dpram packet_dpram_inst (
		.clk    (clk),
		.wr_a   (mem_a),
		.wr_d   (mem_d),
		.host_a (host_a),
		.host_q (host_q)
	);

endmodule

/* tb/rx_badger_tb.sv */
// Rx badger testbench
`timescale 1ns/1ps

module rx_badger_tb
	import badger_pkg::*;
();

	localparam int MAX_ROWS = 8;
	// Idle cycles after data_f before the buffer is read back
	localparam int IDLE_GAP = 12;
	// Cycles per row on top of its length for spacing, the badge and readback setup
	localparam int ROW_GAP  = 24;

	logic       clk;
	logic       arst_n;
	octet_t     data_in;
	logic       data_s;
	logic       data_f;
	logic       rx_mac_hbank;
	logic       rx_mac_accept;
	pbuf_addr_t host_a;
	buf_word_t  host_q;
	octet_t     rx_mac_d;
	mac_addr_t  rx_mac_a;
	logic       rx_mac_wen;
	logic [1:0] rx_mac_buf_status;
	pbuf_addr_t gray_state;
	logic       badge_stb;

	// Table columns, one entry per frame
	int         row_len [MAX_ROWS];
	logic       row_bad [MAX_ROWS];
	logic       row_accept [MAX_ROWS];
	logic       row_host_free [MAX_ROWS];
	status_t    row_status [MAX_ROWS];
	int         num_rows;
	logic       table_ready;
	int         timeout_cycles;

	// Frame under test, buffer readback and the mirror of the MAC memory
	octet_t     frame [2048];
	buf_word_t  rd_buf [2048];
	octet_t     mac_mem [4096];
	buf_word_t  exp_badge [BADGE_LEN];
	octet_t     exp_hdr [MAC_HDR_LEN];
	int         mac_wr_cnt;
	int         stb_cnt;
	int         err_cnt;
	logic [31:0] rng;
	pbuf_addr_t gray_f;

	rx_badger rx_badger_inst (
		.clk               (clk),
		.arst_n            (arst_n),
		.data_in           (data_in),
		.data_s            (data_s),
		.data_f            (data_f),
		.rx_mac_hbank      (rx_mac_hbank),
		.rx_mac_accept     (rx_mac_accept),
		.host_a            (host_a),
		.host_q            (host_q),
		.rx_mac_d          (rx_mac_d),
		.rx_mac_a          (rx_mac_a),
		.rx_mac_wen        (rx_mac_wen),
		.rx_mac_buf_status (rx_mac_buf_status),
		.gray_state        (gray_state),
		.badge_stb         (badge_stb)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Mid-cycle snapshot of the MAC port and the badge strobe
	always @(negedge clk) begin
		if (arst_n && rx_mac_wen) begin
			mac_mem[rx_mac_a] = rx_mac_d;
			mac_wr_cnt++;
		end
		if (arst_n && badge_stb) begin
			stb_cnt++;
		end
	end

	// Plain 32-bit xorshift generator for payload bytes
	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Bit-serial Ethernet CRC, wire order is LSB first
	function automatic logic [31:0] crc_update(logic [31:0] c, octet_t b);
		logic [31:0] r;
		logic        fb;
		int          k;
		r = c;
		for (k = 0; k < 8; k++) begin
			fb = r[0] ^ b[k];
			r = {1'b0, r[31:1]};
			if (fb) begin
				r = r ^ 32'hEDB88320;
			end
		end
		return r;
	endfunction

	function automatic pbuf_addr_t gray_to_bin(pbuf_addr_t g);
		pbuf_addr_t b;
		int         i;
		b[PAW-1] = g[PAW-1];
		for (i = PAW - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	task automatic add_row(input int len, input logic bad, input logic accept,
		input logic host_free, input status_t status);
		row_len[num_rows]       = len;
		row_bad[num_rows]       = bad;
		row_accept[num_rows]    = accept;
		row_host_free[num_rows] = host_free;
		row_status[num_rows]    = status;
		num_rows++;
	endtask

	// Random payload followed by its FCS, optionally with one bit flipped
	task automatic build_frame(input int len, input logic bad);
		logic [31:0] crc;
		int          i;
		crc = 32'hFFFFFFFF;
		for (i = 0; i < len - 4; i++) begin
			rng = xorshift32(rng);
			frame[i] = rng[7:0];
			crc = crc_update(crc, frame[i]);
		end
		crc = ~crc;
		for (i = 0; i < 4; i++) begin
			frame[len-4+i] = crc[8*i +: 8];
		end
		if (bad) begin
			frame[len-1] = frame[len-1] ^ 8'h10;
		end
	endtask

	// Stream the frame, then the one-cycle end strobe
	// Gray pointer is taken mid-cycle while the first octet is on the bus
	task automatic send_frame(input int len);
		int i;
		for (i = 0; i < len; i++) begin
			@(posedge clk);
			data_s  <= 1'b1;
			data_in <= frame[i];
			if (i == 0) begin
				@(negedge clk);
				gray_f = gray_state;
			end
		end
		@(posedge clk);
		data_s  <= 1'b0;
		data_in <= '0;
		data_f  <= 1'b1;
		@(posedge clk);
		data_f  <= 1'b0;
	endtask

	// Pipelined readback, one address per cycle so the ring writer never catches up
	task automatic read_buffer(input pbuf_addr_t base, input int cnt);
		int k;
		for (k = 0; k <= cnt; k++) begin
			@(posedge clk);
			if (k < cnt) begin
				host_a <= pbuf_addr_t'(base + k);
			end
			@(negedge clk);
			if (k > 0) begin
				rd_buf[k-1] = host_q;
			end
		end
	endtask

	initial begin
		wait (table_ready);
		repeat (timeout_cycles) @(posedge clk);
		$display("Run timed out after %0d cycles before the table was done", timeout_cycles);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int         r;
		int         a;
		int         len;
		int         row_errs;
		int         rows_failed;
		logic       saved;
		logic       exp_wbank;
		logic       exp_hbank;
		pbuf_addr_t origin;
		pack_len_t  plen;

		data_in       = '0;
		data_s        = 1'b0;
		data_f        = 1'b0;
		rx_mac_hbank  = 1'b1;
		rx_mac_accept = 1'b0;
		host_a        = '0;
		arst_n        = 1'b0;
		rng           = 32'd72090;
		err_cnt       = 0;
		rows_failed   = 0;
		mac_wr_cnt    = 0;
		stb_cnt       = 0;
		num_rows      = 0;
		table_ready   = 1'b0;

		// Length, bad FCS, accept, host releases its bank, expected status
		add_row(64,   1'b0, 1'b1, 1'b1, 8'h01);
		add_row(100,  1'b1, 1'b0, 1'b0, 8'h00);
		add_row(40,   1'b0, 1'b1, 1'b0, 8'h03);
		add_row(80,   1'b0, 1'b1, 1'b0, 8'h01);
		add_row(72,   1'b0, 1'b1, 1'b1, 8'h01);
		add_row(1530, 1'b0, 1'b1, 1'b1, 8'h05);
		add_row(256,  1'b0, 1'b1, 1'b0, 8'h01);

		timeout_cycles = 0;
		for (r = 0; r < num_rows; r++) begin
			timeout_cycles += row_len[r] + ROW_GAP;
		end
		timeout_cycles = 2 * timeout_cycles;
		table_ready = 1'b1;

		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		if (rx_mac_wen !== 1'b0 || badge_stb !== 1'b0) begin
			$display("ERR rx_mac_wen/badge_stb after reset: got %h/%h expected 0/0",
				rx_mac_wen, badge_stb);
			err_cnt++;
		end
		// Writer bank 0 against host bank 1 leaves one bank free
		exp_wbank = 1'b0;
		exp_hbank = 1'b1;

		for (r = 0; r < num_rows; r++) begin
			row_errs = err_cnt;
			len = row_len[r];
			plen = pack_len_t'(len);
			build_frame(len, row_bad[r]);
			for (a = 0; a < 4096; a++) begin
				mac_mem[a] = 'x;
			end
			saved = exp_wbank != exp_hbank;

			repeat (4) @(posedge clk);
			rx_mac_accept <= row_accept[r];
			mac_wr_cnt = 0;
			stb_cnt = 0;
			@(negedge clk);
			if (rx_mac_buf_status !== {exp_hbank, exp_wbank}) begin
				$display("ERR rx_mac_buf_status: got %h expected %h",
					rx_mac_buf_status, {exp_hbank, exp_wbank});
				err_cnt++;
			end

			send_frame(len);
			origin = gray_to_bin(gray_f) + pbuf_addr_t'(1);
			repeat (IDLE_GAP) @(posedge clk);
			if (stb_cnt != 4) begin
				$display("Row %0d: badge_stb was high for %0d cycles instead of 4", r, stb_cnt);
				err_cnt++;
			end

			read_buffer(origin, len + BADGE_LEN);

			// Expected badge and MAC header from the length and status rules
			exp_badge[0] = {1'b1, 8'h00};
			exp_badge[1] = {1'b1, 1'b0, plen[6:0]};
			exp_badge[2] = {5'b0, plen[10:7]};
			exp_badge[3] = {1'b0, row_status[r]};
			exp_badge[4] = '0;
			exp_hdr[0] = {1'b0, plen[6:0]};
			exp_hdr[1] = {4'h0, plen[10:7]};
			exp_hdr[2] = row_status[r];
			exp_hdr[3] = 8'h00;

			for (a = 0; a < BADGE_LEN; a++) begin
				if (rd_buf[a] !== exp_badge[a]) begin
					$display("ERR host_q badge word %0d: got %03h expected %03h",
						a, rd_buf[a], exp_badge[a]);
					err_cnt++;
				end
			end
			for (a = 0; a < len; a++) begin
				if (rd_buf[BADGE_LEN+a] !== {1'b0, frame[a]}) begin
					$display("ERR host_q payload octet %0d: got %03h expected %03h",
						a, rd_buf[BADGE_LEN+a], {1'b0, frame[a]});
					err_cnt++;
				end
			end

			if (saved) begin
				if (mac_wr_cnt != len + MAC_HDR_LEN) begin
					$display("Row %0d: %0d MAC writes seen instead of %0d",
						r, mac_wr_cnt, len + MAC_HDR_LEN);
					err_cnt++;
				end
				for (a = 0; a < MAC_HDR_LEN; a++) begin
					if (mac_mem[{exp_wbank, 11'(a)}] !== exp_hdr[a]) begin
						$display("ERR rx_mac_d header %0d bank %0d: got %02h expected %02h",
							a, exp_wbank, mac_mem[{exp_wbank, 11'(a)}], exp_hdr[a]);
						err_cnt++;
					end
				end
				for (a = 0; a < len; a++) begin
					if (mac_mem[{exp_wbank, 11'(MAC_HDR_LEN + a)}] !== frame[a]) begin
						$display("ERR rx_mac_d payload %0d bank %0d: got %02h expected %02h",
							a, exp_wbank, mac_mem[{exp_wbank, 11'(MAC_HDR_LEN + a)}], frame[a]);
						err_cnt++;
					end
				end
				if (row_accept[r]) begin
					exp_wbank = ~exp_wbank;
				end
			end else if (mac_wr_cnt != 0) begin
				$display("Row %0d: rx_mac_wen went high with no free bank", r);
				err_cnt++;
			end

			// Host takes the finished bank and hands it back
			if (row_host_free[r]) begin
				@(posedge clk);
				rx_mac_hbank <= ~rx_mac_hbank;
				exp_hbank = ~exp_hbank;
			end

			if (err_cnt != row_errs) begin
				rows_failed++;
			end
			$display("Row %0d: %0d octets, status %02h, MAC %s, %s", r, len, row_status[r],
				saved ? "saved" : "skipped", (err_cnt == row_errs) ? "ok" : "FAILED");
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		if (rx_mac_buf_status !== {exp_hbank, exp_wbank}) begin
			$display("ERR rx_mac_buf_status at end: got %h expected %h",
				rx_mac_buf_status, {exp_hbank, exp_wbank});
			err_cnt++;
		end

		$display("%0d of %0d rows passed, %0d errors", num_rows - rows_failed, num_rows,
			err_cnt);
		if (err_cnt == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* files.f */
verilog/badger_pkg.sv
verilog/frame_scanner.sv
verilog/fcs_checker.sv
verilog/pbuf_writer.sv
verilog/packet_dpram.sv
verilog/rx_badger.sv
tb/rx_badger_tb.sv

/* Bender.yml */
package:
  name: rx_badger

sources:
  # Package first, then the blocks, then the top level
  - files:
      - verilog/badger_pkg.sv
      - verilog/frame_scanner.sv
      - verilog/fcs_checker.sv
      - verilog/pbuf_writer.sv
      - verilog/packet_dpram.sv
      - verilog/rx_badger.sv

  # Testbench with top module rx_badger_tb
  - target: test
    files:
      - tb/rx_badger_tb.sv
